//--- common/cpu_pkg.sv
package cpu_pkg;

  localparam int op_code_bits = 6;
  localparam int reg_idx_bits = 5;

  // top two opcode bits select the class.
  typedef enum logic [op_code_bits-1:0] {
    op_nop  = 6'b000000,
    op_add  = 6'b000001, // add class.
    op_sub  = 6'b000010,
    op_addi = 6'b010001, // immediate class.
    op_subi = 6'b010010,
    op_lw   = 6'b100000,
    op_sw   = 6'b100001,
    op_la   = 6'b100010,
    op_sa   = 6'b100011,
    op_jmp  = 6'b110000, // jump class.
    op_je   = 6'b110001,
    op_jr   = 6'b111000
  } opcode_e;

  typedef enum logic [1:0] {
    mem_none  = 2'b00,
    mem_read  = 2'b01,
    mem_write = 2'b10
  } mem_op_e;

  typedef struct packed {
    logic pc;
    logic if_id;
    logic id_ex;
  } pipe_mask_t;

  typedef struct packed {
    logic rs;
    logic rt;
    logic rd;
  } operand_mask_t;

  typedef struct packed {
    opcode_e                 opcode;
    logic [reg_idx_bits-1:0] rs;
    logic [reg_idx_bits-1:0] rt;
    logic [reg_idx_bits-1:0] rd;
  } instr_slot_t;

  typedef struct packed {
    operand_mask_t src;
    operand_mask_t dst;
    mem_op_e       mem;
  } slot_masks_t;

  typedef struct packed {
    logic        valid;
    instr_slot_t instr;
  } issued_slot_t;

  localparam pipe_mask_t pipe_none  = 3'b000;
  localparam pipe_mask_t pipe_pc    = 3'b100;
  localparam pipe_mask_t pipe_id_ex = 3'b001;
  localparam pipe_mask_t pipe_all   = 3'b111;

  localparam operand_mask_t opnd_none = 3'b000;
  localparam operand_mask_t opnd_rs   = 3'b100;
  localparam operand_mask_t opnd_rt   = 3'b010;
  localparam operand_mask_t opnd_rd   = 3'b001;

  localparam instr_slot_t nop_slot = '{
    opcode: op_nop,
    rs:     '0,
    rt:     '0,
    rd:     '0
  };

endpackage

//--- hdl/operand_mask_decoder.sv
`timescale 1ns/1ns

module operand_mask_decoder (
  input  cpu_pkg::opcode_e     opcode,
  output cpu_pkg::slot_masks_t masks
);

  import cpu_pkg::*;

  logic [1:0] op_class;

  assign op_class = opcode[op_code_bits-1 -: 2];

  always_comb begin
    masks.src = opnd_none;
    masks.dst = opnd_none;
    masks.mem = mem_none;
    if (opcode == op_nop) begin
      masks.src = opnd_none; // no operands.
    end else if (opcode == op_jr) begin
      masks.src = opnd_rs;
    end else begin
      case (op_class)
        2'b00: begin
          masks.src = opnd_rs | opnd_rt;
          masks.dst = opnd_rd;
        end
        2'b01: begin
          masks.src = opnd_rs;
          masks.dst = opnd_rt;
        end
        2'b10: begin
          case (opcode)
            op_lw: begin
              masks.src = opnd_rs; // base register.
              masks.dst = opnd_rt;
              masks.mem = mem_read;
            end
            op_sw: begin
              masks.src = opnd_rs | opnd_rt;
              masks.mem = mem_write;
            end
            op_la: masks.dst = opnd_rt;
            op_sa: masks.src = opnd_rt;
            default: masks.src = opnd_none;
          endcase
        end
        default: masks.src = opnd_none; // jumps use no registers.
      endcase
    end
  end

endmodule

//--- hazard/hazard_detection_unit.sv
`timescale 1ns/1ns

module hazard_detection_unit (
  input  cpu_pkg::instr_slot_t                 slot0,
  input  cpu_pkg::instr_slot_t                 slot1,
  input  cpu_pkg::slot_masks_t                 masks0,
  input  cpu_pkg::slot_masks_t                 masks1,
  input  logic                                 first,
  input  cpu_pkg::mem_op_e                     ex_mem_op,
  input  logic [cpu_pkg::reg_idx_bits-1:0]     ex_rt,
  output cpu_pkg::pipe_mask_t                  stall0,
  output cpu_pkg::pipe_mask_t                  stall1,
  output cpu_pkg::pipe_mask_t                  nop0,
  output cpu_pkg::pipe_mask_t                  nop1,
  output logic                                 clear0,
  output logic                                 clear1
);

  import cpu_pkg::*;

  instr_slot_t   older;
  instr_slot_t   younger;
  operand_mask_t older_dst;
  operand_mask_t younger_src;
  logic          ex_load;
  logic          load_use0;
  logic          load_use1;
  logic          pair_dep;

  function automatic logic writes_reg(
    input operand_mask_t           dst,
    input instr_slot_t             s,
    input logic [reg_idx_bits-1:0] r
  );
    writes_reg = (dst.rt && s.rt == r) || (dst.rd && s.rd == r);
  endfunction

  // first set means slot 1 is older.
  assign older       = first ? slot1 : slot0;
  assign younger     = first ? slot0 : slot1;
  assign older_dst   = first ? masks1.dst : masks0.dst;
  assign younger_src = first ? masks0.src : masks1.src;

  assign ex_load   = (ex_mem_op == mem_read);
  assign load_use0 = ex_load && (slot0.rs == ex_rt || slot0.rt == ex_rt);
  assign load_use1 = ex_load && (slot1.rs == ex_rt || slot1.rt == ex_rt);

  assign pair_dep = (younger_src.rs && writes_reg(older_dst, older, younger.rs)) ||
                    (younger_src.rt && writes_reg(older_dst, older, younger.rt));

  always_comb begin
    stall0 = pipe_none;
    stall1 = pipe_none;
    nop0   = pipe_none;
    nop1   = pipe_none;
    clear0 = 1'b0;
    clear1 = 1'b0;
    if (load_use0 || load_use1) begin
      stall0 = pipe_all; // whole pair waits a cycle.
      stall1 = pipe_all;
      nop0   = pipe_id_ex;
      nop1   = pipe_id_ex;
    end else if (pair_dep) begin
      if (first) begin
        stall0 = pipe_all;
        nop0   = pipe_id_ex;
        stall1 = pipe_pc;
        clear1 = 1'b1; // older slot goes now.
      end else begin
        stall1 = pipe_all;
        nop1   = pipe_id_ex;
        stall0 = pipe_pc;
        clear0 = 1'b1;
      end
    end
  end

  // only the older slot of a pair is ever retired early.
  always_comb begin
    a_clear_excl: assert (!(clear0 && clear1))
      else $error("hazard unit cleared both slots");
  end

endmodule

//--- hdl/if_id_pair_reg.sv
`timescale 1ns/1ns

module if_id_pair_reg (
  input  logic                 clk,
  input  logic                 arst_n,
  input  cpu_pkg::instr_slot_t fetch_pair0,
  input  cpu_pkg::instr_slot_t fetch_pair1,
  input  logic                 fetch_first,
  input  cpu_pkg::pipe_mask_t  stall0,
  input  cpu_pkg::pipe_mask_t  stall1,
  input  logic                 clear0,
  input  logic                 clear1,
  output cpu_pkg::instr_slot_t slot0,
  output cpu_pkg::instr_slot_t slot1,
  output logic                 first
);

  import cpu_pkg::*;

  instr_slot_t fetch_in [2];
  pipe_mask_t  stall_in [2];
  logic        clear_in [2];
  instr_slot_t slot_q   [2];

  assign fetch_in[0] = fetch_pair0;
  assign fetch_in[1] = fetch_pair1;
  assign stall_in[0] = stall0;
  assign stall_in[1] = stall1;
  assign clear_in[0] = clear0;
  assign clear_in[1] = clear1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2; i++) begin
        slot_q[i] <= nop_slot;
      end
      first <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (clear_in[i]) begin
          slot_q[i] <= nop_slot; // issued ahead of its partner.
        end else if (!stall_in[i].if_id) begin
          slot_q[i] <= fetch_in[i];
        end
      end
      if (!stall0.if_id && !stall1.if_id) begin
        first <= fetch_first; // order stays with a held slot.
      end
    end
  end

  assign slot0 = slot_q[0];
  assign slot1 = slot_q[1];

endmodule

//--- hdl/id_ex_pair_reg.sv
`timescale 1ns/1ns

module id_ex_pair_reg (
  input  logic                             clk,
  input  logic                             arst_n,
  input  cpu_pkg::instr_slot_t             slot0,
  input  cpu_pkg::instr_slot_t             slot1,
  input  cpu_pkg::slot_masks_t             masks0,
  input  cpu_pkg::slot_masks_t             masks1,
  input  cpu_pkg::pipe_mask_t              stall0,
  input  cpu_pkg::pipe_mask_t              stall1,
  input  cpu_pkg::pipe_mask_t              nop0,
  input  cpu_pkg::pipe_mask_t              nop1,
  output cpu_pkg::issued_slot_t            issue0,
  output cpu_pkg::issued_slot_t            issue1,
  output cpu_pkg::mem_op_e                 ex_mem_op,
  output logic [cpu_pkg::reg_idx_bits-1:0] ex_rt
);

  import cpu_pkg::*;

  instr_slot_t slot_in  [2];
  slot_masks_t masks_in [2];
  pipe_mask_t  stall_in [2];
  pipe_mask_t  nop_in   [2];
  logic        valid_q  [2];
  mem_op_e     mem_q    [2];
  instr_slot_t instr_q  [2];

  assign slot_in[0]  = slot0;
  assign slot_in[1]  = slot1;
  assign masks_in[0] = masks0;
  assign masks_in[1] = masks1;
  assign stall_in[0] = stall0;
  assign stall_in[1] = stall1;
  assign nop_in[0]   = nop0;
  assign nop_in[1]   = nop1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2; i++) begin
        valid_q[i] <= 1'b0;
        mem_q[i]   <= mem_none;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (nop_in[i].id_ex) begin
          valid_q[i] <= 1'b0; // bubble.
          mem_q[i]   <= mem_none;
        end else if (!stall_in[i].id_ex) begin
          valid_q[i] <= (slot_in[i].opcode != op_nop);
          mem_q[i]   <= masks_in[i].mem;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (!stall_in[i].id_ex) begin
        instr_q[i] <= slot_in[i];
      end
    end
  end

  assign issue0 = '{valid: valid_q[0], instr: instr_q[0]};
  assign issue1 = '{valid: valid_q[1], instr: instr_q[1]};

  // slot 0 wins when both slots touch memory.
  assign ex_mem_op = (mem_q[0] != mem_none) ? mem_q[0] : mem_q[1];
  assign ex_rt     = (mem_q[0] != mem_none) ? instr_q[0].rt : instr_q[1].rt;

  a_nop0_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    nop0.id_ex |=> !issue0.valid);
  a_nop1_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    nop1.id_ex |=> !issue1.valid);

endmodule

//--- hdl/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  cpu_pkg::instr_slot_t  fetch_pair0,
  input  cpu_pkg::instr_slot_t  fetch_pair1,
  input  logic                  fetch_first,
  output logic                  fetch_hold,
  output cpu_pkg::issued_slot_t issue0,
  output cpu_pkg::issued_slot_t issue1
);

  import cpu_pkg::*;

  instr_slot_t             slot0;
  instr_slot_t             slot1;
  logic                    first;
  slot_masks_t             masks0;
  slot_masks_t             masks1;
  pipe_mask_t              stall0;
  pipe_mask_t              stall1;
  pipe_mask_t              nop0;
  pipe_mask_t              nop1;
  logic                    clear0;
  logic                    clear1;
  mem_op_e                 ex_mem_op;
  logic [reg_idx_bits-1:0] ex_rt;

  if_id_pair_reg u_if_id (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_pair0 (fetch_pair0),
    .fetch_pair1 (fetch_pair1),
    .fetch_first (fetch_first),
    .stall0      (stall0),
    .stall1      (stall1),
    .clear0      (clear0),
    .clear1      (clear1),
    .slot0       (slot0),
    .slot1       (slot1),
    .first       (first)
  );

  operand_mask_decoder u_dec0 (
    .opcode (slot0.opcode),
    .masks  (masks0)
  );

  operand_mask_decoder u_dec1 (
    .opcode (slot1.opcode),
    .masks  (masks1)
  );

  hazard_detection_unit u_hazard (
    .slot0     (slot0),
    .slot1     (slot1),
    .masks0    (masks0),
    .masks1    (masks1),
    .first     (first),
    .ex_mem_op (ex_mem_op),
    .ex_rt     (ex_rt),
    .stall0    (stall0),
    .stall1    (stall1),
    .nop0      (nop0),
    .nop1      (nop1),
    .clear0    (clear0),
    .clear1    (clear1)
  );

  id_ex_pair_reg u_id_ex (
    .clk       (clk),
    .arst_n    (arst_n),
    .slot0     (slot0),
    .slot1     (slot1),
    .masks0    (masks0),
    .masks1    (masks1),
    .stall0    (stall0),
    .stall1    (stall1),
    .nop0      (nop0),
    .nop1      (nop1),
    .issue0    (issue0),
    .issue1    (issue1),
    .ex_mem_op (ex_mem_op),
    .ex_rt     (ex_rt)
  );

  assign fetch_hold = stall0.pc | stall1.pc; // pc bit of merged stalls.

endmodule

//--- tests/issue_checker.sv
`timescale 1ns/1ns

module issue_checker (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        fetch_first,
  input  logic                        fetch_hold,
  input  cpu_pkg::issued_slot_t       issue0,
  input  cpu_pkg::issued_slot_t       issue1,
  input  logic                        start,
  input  logic [8*14-1:0]             exp_name,
  input  int                          exp_n,
  input  cpu_pkg::instr_slot_t [3:0]  exp_seq,
  input  int                          exp_holds,
  input  int                          exp_gaps,
  input  int                          exp_cycles,
  output logic                        done,
  output int                          tests_run,
  output int                          errors
);

  import cpu_pkg::*;

  logic flag_if;
  logic flag_ex;
  logic start_q;
  logic active;
  logic finished;
  int   edges;
  int   matched;
  int   holds;
  int   gaps;
  int   cycles;
  int   test_errs;

  // order flag follows the pair through if/id and id/ex.
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flag_if <= 1'b0;
      flag_ex <= 1'b0;
      start_q <= 1'b0;
      edges   <= 0;
      done    <= 1'b0;
    end else begin
      if (!fetch_hold) flag_if <= fetch_first; // pair accepted.
      flag_ex <= flag_if;
      start_q <= start;
      edges   <= start ? 1 : edges + 1;
      if (start) done <= 1'b0;
      else if (finished) done <= 1'b1;
    end
  end

  task report_value(input string what, input int expv, input int act);
    $display("ERR %0s: %0s expected %0d actual %0d", exp_name, what, expv, act);
    test_errs++;
  endtask

  task compare_next(input instr_slot_t act);
    if (matched >= exp_n) begin
      $display("%0s: more instructions issued than expected", exp_name);
      test_errs++;
    end else if (act !== exp_seq[matched]) begin
      $display("ERR %0s: issue %0d expected %h actual %h", exp_name, matched,
               exp_seq[matched], act);
      test_errs++;
    end
    matched++;
  endtask

  always @(negedge clk) begin
    if (!arst_n) begin
      active    = 1'b0;
      finished  = 1'b0;
      tests_run = 0;
      errors    = 0;
    end else begin
      if (start_q) begin
        active    = 1'b1;
        finished  = 1'b0;
        matched   = 0;
        holds     = 0;
        gaps      = 0;
        cycles    = 0;
        test_errs = 0;
      end
      if (!active) begin
        if (issue0.valid || issue1.valid) begin
          $display("an issue slot was valid with no pair outstanding");
          errors++;
        end
        if (fetch_hold) begin
          $display("fetch_hold was high with no pair outstanding");
          errors++;
        end
      end else begin
        if (fetch_hold) holds++;
        if (!issue0.valid && !issue1.valid) begin
          if (matched > 0) gaps++; // bubble inside the test.
        end else begin
          cycles++;
          if (matched == 0 && edges != 2) report_value("edges to first issue", 2, edges);
          if (issue0.valid && issue1.valid) begin
            compare_next(flag_ex ? issue1.instr : issue0.instr);
            compare_next(flag_ex ? issue0.instr : issue1.instr);
          end else begin
            compare_next(issue0.valid ? issue0.instr : issue1.instr);
          end
        end
        if (matched >= exp_n) begin
          if (holds != exp_holds) report_value("fetch_hold cycles", exp_holds, holds);
          if (gaps != exp_gaps) report_value("bubble cycles", exp_gaps, gaps);
          if (cycles != exp_cycles) report_value("issue cycles", exp_cycles, cycles);
          $display("%0s: %0s", exp_name, (test_errs == 0) ? "ok" : "mismatch");
          tests_run++;
          errors   = errors + test_errs;
          active   = 1'b0;
          finished = 1'b1;
        end
      end
    end
  end

endmodule

//--- tests/issue_stage_tb.sv
`timescale 1ns/1ns

module issue_stage_tb;

  import cpu_pkg::*;

  localparam int n_tests    = 12;
  localparam int clk_period = 100;

  typedef logic [8*14-1:0] name_t;

  // one order nibble per expected issue picks pair a slot 0 or 1 or pair b slot 2 or 3.
  typedef struct packed {
    name_t       name;
    instr_slot_t a0;
    instr_slot_t a1;
    logic        a_first;
    logic        has_b;
    instr_slot_t b0;
    instr_slot_t b1;
    logic        b_first;
    logic [15:0] order;
    logic [2:0]  n_exp;
    logic [3:0]  holds;
    logic [3:0]  gaps;
    logic [3:0]  cycles;
  } test_t;

  logic              clk;
  logic              arst_n;
  instr_slot_t       fetch_pair0;
  instr_slot_t       fetch_pair1;
  logic              fetch_first;
  logic              fetch_hold;
  issued_slot_t      issue0;
  issued_slot_t      issue1;
  logic              start;
  name_t             exp_name;
  int                exp_n;
  instr_slot_t [3:0] exp_seq;
  int                exp_holds;
  int                exp_gaps;
  int                exp_cycles;
  logic              done;
  int                tests_run;
  int                errors;
  test_t             tbl [n_tests];

  issue_stage uut (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_pair0 (fetch_pair0),
    .fetch_pair1 (fetch_pair1),
    .fetch_first (fetch_first),
    .fetch_hold  (fetch_hold),
    .issue0      (issue0),
    .issue1      (issue1)
  );

  issue_checker chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_first (fetch_first),
    .fetch_hold  (fetch_hold),
    .issue0      (issue0),
    .issue1      (issue1),
    .start       (start),
    .exp_name    (exp_name),
    .exp_n       (exp_n),
    .exp_seq     (exp_seq),
    .exp_holds   (exp_holds),
    .exp_gaps    (exp_gaps),
    .exp_cycles  (exp_cycles),
    .done        (done),
    .tests_run   (tests_run),
    .errors      (errors)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic instr_slot_t ins(opcode_e op, int rs, int rt, int rd);
    ins = '{opcode: op, rs: 5'(rs), rt: 5'(rt), rd: 5'(rd)};
  endfunction

  function automatic test_t one_pair(name_t name, instr_slot_t a0, instr_slot_t a1,
                                     logic first, logic [15:0] order, int n,
                                     int holds, int gaps, int cycles);
    one_pair.name    = name;
    one_pair.a0      = a0;
    one_pair.a1      = a1;
    one_pair.a_first = first;
    one_pair.has_b   = 1'b0;
    one_pair.b0      = nop_slot;
    one_pair.b1      = nop_slot;
    one_pair.b_first = 1'b0;
    one_pair.order   = order;
    one_pair.n_exp   = 3'(n);
    one_pair.holds   = 4'(holds);
    one_pair.gaps    = 4'(gaps);
    one_pair.cycles  = 4'(cycles);
  endfunction

  // zero fields are unused; high registers keep them clear of every hazard.
  function automatic instr_slot_t fill_unused(instr_slot_t s);
    fill_unused = s;
    if (s.rs == 0) fill_unused.rs = 5'($urandom_range(31, 24));
    if (s.rt == 0) fill_unused.rt = 5'($urandom_range(31, 24));
    if (s.rd == 0) fill_unused.rd = 5'($urandom_range(31, 24));
  endfunction

  task automatic build_table();
    tbl[0]  = one_pair("indep", ins(op_add, 2, 4, 5), ins(op_addi, 6, 7, 0),
                       1'b0, 16'h01, 2, 0, 0, 1);
    tbl[1]  = one_pair("add_add_f0", ins(op_add, 2, 4, 3), ins(op_add, 3, 6, 8),
                       1'b0, 16'h01, 2, 1, 0, 2);
    tbl[2]  = one_pair("add_add_f1", ins(op_add, 6, 3, 8), ins(op_add, 2, 4, 3),
                       1'b1, 16'h10, 2, 1, 0, 2);
    tbl[3]  = one_pair("lw_sw_f0", ins(op_lw, 2, 11, 0), ins(op_sw, 1, 11, 0),
                       1'b0, 16'h01, 2, 2, 1, 2);
    tbl[4]  = one_pair("lw_sw_f1", ins(op_sw, 1, 17, 0), ins(op_lw, 2, 17, 0),
                       1'b1, 16'h10, 2, 2, 1, 2);
    tbl[5]  = one_pair("la_sa_f0", ins(op_la, 0, 10, 0), ins(op_sa, 0, 10, 0),
                       1'b0, 16'h01, 2, 1, 0, 2);
    tbl[6]  = one_pair("la_sa_f1", ins(op_sa, 0, 12, 0), ins(op_la, 0, 12, 0),
                       1'b1, 16'h10, 2, 1, 0, 2);
    tbl[7]  = one_pair("load_use", ins(op_lw, 4, 9, 0), ins(op_add, 5, 6, 7),
                       1'b0, 16'h0123, 4, 1, 1, 2);
    tbl[7].has_b   = 1'b1;
    tbl[7].b0      = ins(op_add, 9, 13, 14); // reads the loaded register.
    tbl[7].b1      = ins(op_jmp, 0, 0, 0);
    tbl[7].b_first = 1'b0;
    tbl[8]  = one_pair("jmp_after_add", ins(op_add, 2, 4, 13), ins(op_jmp, 13, 13, 13),
                       1'b0, 16'h01, 2, 0, 0, 1);
    tbl[9]  = one_pair("add_after_nop", ins(op_add, 3, 3, 3), ins(op_nop, 3, 3, 3),
                       1'b1, 16'h0, 1, 0, 0, 1);
    tbl[10] = one_pair("add_after_jr", ins(op_jr, 15, 15, 15), ins(op_add, 15, 15, 18),
                       1'b0, 16'h01, 2, 0, 0, 1);
    tbl[11] = one_pair("jr_reads_add", ins(op_jr, 12, 0, 0), ins(op_add, 2, 4, 12),
                       1'b1, 16'h10, 2, 1, 0, 2);
  endtask

  task automatic apply_test(int t);
    test_t       cur;
    instr_slot_t a0;
    instr_slot_t a1;
    instr_slot_t b0;
    instr_slot_t b1;
    int          code;
    cur = tbl[t];
    a0  = fill_unused(cur.a0);
    a1  = fill_unused(cur.a1);
    b0  = fill_unused(cur.b0);
    b1  = fill_unused(cur.b1);
    for (int k = 0; k < 4; k++) begin
      exp_seq[k] = nop_slot;
      if (k < int'(cur.n_exp)) begin
        code = int'((cur.order >> (4 * (int'(cur.n_exp) - 1 - k))) & 16'h3);
        case (code)
          0: exp_seq[k] = a0;
          1: exp_seq[k] = a1;
          2: exp_seq[k] = b0;
          default: exp_seq[k] = b1;
        endcase
      end
    end
    exp_name    = cur.name;
    exp_n       = int'(cur.n_exp);
    exp_holds   = int'(cur.holds);
    exp_gaps    = int'(cur.gaps);
    exp_cycles  = int'(cur.cycles);
    fetch_pair0 = a0;
    fetch_pair1 = a1;
    fetch_first = cur.a_first;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (fetch_hold) @(negedge clk); // re-present while held.
    if (cur.has_b) begin
      fetch_pair0 = b0;
      fetch_pair1 = b1;
      fetch_first = cur.b_first;
      @(negedge clk);
      while (fetch_hold) @(negedge clk);
    end
    fetch_pair0 = nop_slot;
    fetch_pair1 = nop_slot;
    fetch_first = 1'b0;
    while (!done) @(negedge clk);
  endtask

  initial begin
    void'($urandom(64294));
    clk         = 1'b0;
    arst_n      = 1'b0;
    fetch_pair0 = nop_slot;
    fetch_pair1 = nop_slot;
    fetch_first = 1'b0;
    start       = 1'b0;
    exp_name    = '0;
    exp_n       = 0;
    exp_seq     = '0;
    exp_holds   = 0;
    exp_gaps    = 0;
    exp_cycles  = 0;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk); // idle outputs checked here.
    for (int t = 0; t < n_tests; t++) begin
      apply_test(t);
    end
    repeat (2) @(negedge clk);
    $display("tests run %0d of %0d, errors %0d", tests_run, n_tests, errors);
    if (errors == 0 && tests_run == n_tests) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #((n_tests * 4 + 20) * clk_period);
    $display("watchdog expired before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- issue_stage.f
common/cpu_pkg.sv
hdl/operand_mask_decoder.sv
hazard/hazard_detection_unit.sv
hdl/if_id_pair_reg.sv
hdl/id_ex_pair_reg.sv
hdl/issue_stage.sv
tests/issue_checker.sv
tests/issue_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module issue_stage_tb \
  -f issue_stage.f -o issue_stage_sim > build.log 2>&1 \
  && ./obj_dir/issue_stage_sim > sim.log 2>&1 \
  || { echo "build or run failed"; cat build.log; exit 1; }
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
